// File: common/vecAlu_params.svh
`ifndef VECALU_PARAMS_SVH
`define VECALU_PARAMS_SVH

// number of vector lanes
`define LANES 4

// element width in bits
`define XLEN 32

// opcode width of an issued instruction
`define OPW 5

// shift amount width, taken from B
`define SHW 5

`endif

// File: common/vecAluPkg.sv
`include "vecAlu_params.svh"

package vecAluPkg;

	typedef logic [`XLEN-1:0] wordT; // one vector element
	typedef logic [`OPW-1:0] opCodeT; // raw opcode
	typedef logic [`LANES-1:0] laneMaskT; // one bit per lane
	typedef wordT [`LANES-1:0] vecT; // full vector operand

	typedef enum logic [`OPW-1:0] {
		opAnd    = 5'd0,
		opOr     = 5'd1,
		opAdd    = 5'd2,
		opSub    = 5'd3,
		opXor    = 5'd4,
		opSll    = 5'd5,
		opSrl    = 5'd6,
		opSltu   = 5'd7,
		opSlt    = 5'd8,
		opSge    = 5'd9,
		opSgt    = 5'd10,
		opLhi    = 5'd12,
		opMov    = 5'd14,
		opAddf   = 5'd15,
		opCvti2f = 5'd30,
		opCvtf2i = 5'd31
	} aluOpE;

	typedef struct packed {
		vecT a;
		vecT b;
		opCodeT opCode;
		logic bcastB; // use b element 0 in every lane
	} issueReqT;

	typedef struct packed {
		aluOpE op;
		vecT a;
		vecT b;
	} laneCmdT;

	typedef struct packed {
		wordT result;
		logic carry;
		logic overflow;
		logic setFlag;
		logic zero;
	} laneOutT;

	typedef struct packed {
		vecT result;
		laneMaskT carryMask;
		laneMaskT overflowMask;
		laneMaskT setMask;
		laneMaskT zeroMask;
		logic allZero;
	} vecResultT;

endpackage

// File: aluLane/floatOps.sv
`timescale 1ns/1ps

module floatOps import vecAluPkg::*; (
	input wordT a,
	input wordT b,
	output wordT addfRes,
	output wordT f2iRes,
	output wordT i2fRes
);

	logic [7:0] expA;
	logic [7:0] expB;
	logic [23:0] sigA;
	logic [23:0] sigB;
	logic [7:0] bigExp;
	logic [7:0] smallExp;
	logic [23:0] bigSig;
	logic [23:0] smallSig;
	logic [7:0] expDiff;
	logic [23:0] alignedSig;
	logic [24:0] sigSum;
	logic [7:0] sumExp;
	logic [22:0] sumMant;
	logic [7:0] lsh;
	logic [7:0] rsh;
	wordT sigWide;
	logic [4:0] lzc;
	wordT normA;

	assign expA = a[30:23];
	assign expB = b[30:23];
	assign sigA = (expA == 8'd0) ? 24'd0 : {1'b1, a[22:0]}; // exponent 0 reads as zero
	assign sigB = (expB == 8'd0) ? 24'd0 : {1'b1, b[22:0]};

	// addf, positive operands only
	always_comb begin
		if (expA >= expB) begin
			bigExp = expA;
			bigSig = sigA;
			smallExp = expB;
			smallSig = sigB;
		end else begin
			bigExp = expB;
			bigSig = sigB;
			smallExp = expA;
			smallSig = sigA;
		end
		expDiff = bigExp - smallExp;
		alignedSig = (expDiff >= 8'd24) ? 24'd0 : smallSig >> expDiff; // gap too wide
		sigSum = {1'b0, bigSig} + {1'b0, alignedSig};
		if (sigSum[24]) begin
			sumExp = bigExp + 8'd1;
			sumMant = sigSum[23:1];
		end else begin
			sumExp = bigExp;
			sumMant = sigSum[22:0];
		end
		if (expA == 8'd0 && expB == 8'd0)
			addfRes = '0;
		else
			addfRes = {1'b0, sumExp, sumMant};
	end

	// cvtf2i, binary point sits 150 exponent steps up
	assign sigWide = {8'h00, 1'b1, a[22:0]};
	assign lsh = expA - 8'd150;
	assign rsh = 8'd150 - expA;

	always_comb begin
		if (expA < 8'd127)
			f2iRes = '0;
		else if (expA >= 8'd150)
			f2iRes = (lsh >= 8'd32) ? '0 : sigWide << lsh[4:0];
		else
			f2iRes = sigWide >> rsh[4:0];
	end

	// cvti2f, priority leading-zero count
	always_comb begin
		lzc = 5'd0;
		for (int i = 0; i < 32; i++) begin
			if (a[i])
				lzc = 5'(31 - i); // highest set bit wins
		end
	end

	assign normA = a << lzc;
	assign i2fRes = (a == '0) ? '0 : {1'b0, 8'd158 - {3'b000, lzc}, normA[30:8]};

endmodule

// File: aluLane/aluLane.sv
`timescale 1ns/1ps
`include "vecAlu_params.svh"

module aluLane import vecAluPkg::*; (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input aluOpE op,
	input wordT a,
	input wordT b,
	output logic outValid,
	output laneOutT out
);

	logic [`XLEN:0] sum33; // unsigned sum with carry out
	logic [`XLEN-1:0] lowSum; // carry into the sign bit
	wordT sumRes;
	wordT diffRes;
	wordT addfRes;
	wordT f2iRes;
	wordT i2fRes;
	logic [`SHW-1:0] shAmt;
	logic sLess;
	logic carryBit;
	logic ovfBit;
	wordT nextRes;
	logic nextSet;

	floatOps uFloat (
		.a(a),
		.b(b),
		.addfRes(addfRes),
		.f2iRes(f2iRes),
		.i2fRes(i2fRes)
	);

	assign sum33 = {1'b0, a} + {1'b0, b};
	assign lowSum = {1'b0, a[`XLEN-2:0]} + {1'b0, b[`XLEN-2:0]};
	assign sumRes = sum33[`XLEN-1:0];
	assign diffRes = a - b;
	assign carryBit = sum33[`XLEN];
	assign ovfBit = lowSum[`XLEN-1] ^ sum33[`XLEN]; // carry in xor carry out
	assign shAmt = b[`SHW-1:0];
	assign sLess = $signed(a) < $signed(b);

	always_comb begin
		nextSet = 1'b0;
		case (op)
			opAnd: nextRes = a & b;
			opOr: nextRes = a | b;
			opSub: nextRes = diffRes;
			opXor: nextRes = a ^ b;
			opSll: nextRes = a << shAmt;
			opSrl: nextRes = a >> shAmt;
			opSltu: begin
				nextRes = diffRes; // flag carries the compare
				nextSet = a < b;
			end
			opSlt: begin
				nextRes = wordT'(sLess);
				nextSet = sLess;
			end
			opSge: begin
				nextRes = wordT'(!sLess);
				nextSet = !sLess;
			end
			opSgt: begin
				nextRes = wordT'(a > b); // unsigned compare
				nextSet = a > b;
			end
			opLhi: nextRes = {b[15:0], 16'h0000};
			opMov: nextRes = a;
			opAddf: nextRes = addfRes;
			opCvtf2i: nextRes = f2iRes;
			opCvti2f: nextRes = i2fRes;
			default: nextRes = sumRes; // opAdd
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
			out <= '0;
		end else begin
			outValid <= inValid;
			if (inValid) begin
				out.result <= nextRes;
				out.carry <= carryBit;
				out.overflow <= ovfBit;
				out.setFlag <= nextSet;
				out.zero <= (nextRes == '0);
			end
		end
	end

endmodule

// File: hw/issueDecode.sv
`timescale 1ns/1ps
`include "vecAlu_params.svh"

module issueDecode import vecAluPkg::*; (
	input logic clk,
	input logic arstN,
	input logic issueValid,
	input issueReqT req,
	output logic cmdValid,
	output laneCmdT cmd
);

	aluOpE decOp;
	vecT laneB;

	// opcode map, anything outside the set runs as add
	always_comb begin
		case (req.opCode)
			opAnd,
			opOr,
			opAdd,
			opSub,
			opXor,
			opSll,
			opSrl,
			opSltu,
			opSlt,
			opSge,
			opSgt,
			opLhi,
			opMov,
			opAddf,
			opCvti2f,
			opCvtf2i: begin
				decOp = aluOpE'(req.opCode);
			end
			default: begin
				decOp = opAdd;
			end
		endcase
	end

	// B operand per lane
	always_comb begin
		for (int i = 0; i < `LANES; i++) begin
			laneB[i] = req.bcastB ? req.b[0] : req.b[i]; // scalar B broadcast
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cmdValid <= 1'b0;
			cmd <= '0;
		end else begin
			cmdValid <= issueValid;
			if (issueValid) begin
				cmd.op <= decOp;
				cmd.a <= req.a;
				cmd.b <= laneB;
			end
		end
	end

endmodule

// File: hw/resultCollect.sv
`timescale 1ns/1ps
`include "vecAlu_params.svh"

module resultCollect import vecAluPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [`LANES-1:0] laneValid,
	input laneOutT [`LANES-1:0] laneOut,
	output logic resultValid,
	output vecResultT result
);

	vecResultT nextRes;

	always_comb begin
		nextRes = '0;
		for (int i = 0; i < `LANES; i++) begin
			nextRes.result[i] = laneOut[i].result;
			nextRes.carryMask[i] = laneOut[i].carry;
			nextRes.overflowMask[i] = laneOut[i].overflow;
			nextRes.setMask[i] = laneOut[i].setFlag;
			nextRes.zeroMask[i] = laneOut[i].zero;
		end
		nextRes.allZero = &nextRes.zeroMask; // whole vector is zero
	end

	// lanes run in lockstep, lane 0 stands for all
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resultValid <= 1'b0;
			result <= '0;
		end else begin
			resultValid <= laneValid[0];
			if (laneValid[0])
				result <= nextRes;
		end
	end

endmodule

// File: hw/vecAluTop.sv
`timescale 1ns/1ps
`include "vecAlu_params.svh"

module vecAluTop import vecAluPkg::*; (
	input logic clk,
	input logic arstN,
	input logic issueValid,
	input issueReqT req,
	output logic resultValid,
	output vecResultT result
);

	logic cmdValid;
	laneCmdT cmd;
	logic [`LANES-1:0] laneValid;
	laneOutT [`LANES-1:0] laneOut;

	issueDecode uIssue (
		.clk(clk),
		.arstN(arstN),
		.issueValid(issueValid),
		.req(req),
		.cmdValid(cmdValid),
		.cmd(cmd)
	);

	for (genvar i = 0; i < `LANES; i++) begin : gLane
		aluLane uLane (
			.clk(clk),
			.arstN(arstN),
			.inValid(cmdValid),
			.op(cmd.op),
			.a(cmd.a[i]),
			.b(cmd.b[i]),
			.outValid(laneValid[i]),
			.out(laneOut[i])
		);
	end

	resultCollect uCollect (
		.clk(clk),
		.arstN(arstN),
		.laneValid(laneValid),
		.laneOut(laneOut),
		.resultValid(resultValid),
		.result(result)
	);

endmodule

// File: verification/vecAluChecker.sv
`timescale 1ns/1ps
`include "vecAlu_params.svh"

module vecAluChecker import vecAluPkg::*; (
	input logic clk,
	input logic arstN,
	input logic issueValid,
	input issueReqT req,
	input logic resultValid,
	input vecResultT result,
	output int mismatches,
	output int otherErrors,
	output int checked,
	output int pending
);

	vecResultT expQ[$];
	int dueQ[$]; // cycle at which each result is due
	int cycle;
	vecResultT expVal;
	int dueCycle;

	function automatic wordT addfRef(wordT a, wordT b);
		logic [7:0] ea;
		logic [7:0] eb;
		logic [7:0] eOut;
		logic [24:0] ma;
		logic [24:0] mb;
		logic [24:0] sum;
		int gap;
		ea = a[30:23];
		eb = b[30:23];
		if (ea == 8'd0 && eb == 8'd0)
			return '0;
		ma = (ea == 8'd0) ? 25'd0 : {2'b01, a[22:0]};
		mb = (eb == 8'd0) ? 25'd0 : {2'b01, b[22:0]};
		gap = int'(ea) - int'(eb);
		if (gap >= 0) begin
			mb = (gap >= 24) ? 25'd0 : mb >> gap;
			eOut = ea;
		end else begin
			ma = (-gap >= 24) ? 25'd0 : ma >> (-gap);
			eOut = eb;
		end
		sum = ma + mb;
		if (sum >= 25'h1000000) begin
			sum = sum >> 1; // renormalize
			eOut = eOut + 8'd1;
		end
		return {1'b0, eOut, sum[22:0]};
	endfunction

	function automatic wordT f2iRef(wordT a);
		int e;
		wordT sig;
		e = int'(a[30:23]);
		sig = {8'h00, 1'b1, a[22:0]};
		if (e < 127)
			return '0;
		if (e >= 150)
			return sig << (e - 150);
		return sig >> (150 - e);
	endfunction

	function automatic wordT i2fRef(wordT a);
		int msb;
		logic [22:0] mant;
		if (a == '0)
			return '0;
		msb = 0;
		for (int i = 0; i < 32; i++)
			if (a[i])
				msb = i;
		if (msb >= 23)
			mant = 23'(a >> (msb - 23));
		else
			mant = 23'(a << (23 - msb));
		return {1'b0, 8'(127 + msb), mant};
	endfunction

	function automatic laneOutT laneRef(opCodeT opc, wordT a, wordT b);
		laneOutT o;
		logic [32:0] wide;
		o = '0;
		wide = {1'b0, a} + {1'b0, b};
		o.carry = wide[32];
		o.overflow = (a[31] == b[31]) && (wide[31] != a[31]);
		case (opc)
			5'd0: o.result = a & b;
			5'd1: o.result = a | b;
			5'd3: o.result = a - b;
			5'd4: o.result = a ^ b;
			5'd5: o.result = a << b[4:0];
			5'd6: o.result = a >> b[4:0];
			5'd7: begin
				o.result = a - b; // sltu keeps the difference
				o.setFlag = a < b;
			end
			5'd8: o.setFlag = $signed(a) < $signed(b);
			5'd9: o.setFlag = $signed(a) >= $signed(b);
			5'd10: o.setFlag = a > b; // unsigned compare
			5'd12: o.result = {b[15:0], 16'h0000};
			5'd14: o.result = a;
			5'd15: o.result = addfRef(a, b);
			5'd30: o.result = i2fRef(a);
			5'd31: o.result = f2iRef(a);
			default: o.result = a + b; // add and unknown codes
		endcase
		if (opc == 5'd8 || opc == 5'd9 || opc == 5'd10)
			o.result = {31'd0, o.setFlag};
		o.zero = (o.result == '0);
		return o;
	endfunction

	function automatic vecResultT vecRef(issueReqT r);
		vecResultT v;
		laneOutT lo;
		v = '0;
		for (int i = 0; i < `LANES; i++) begin
			lo = laneRef(r.opCode, r.a[i], r.bcastB ? r.b[0] : r.b[i]);
			v.result[i] = lo.result;
			v.carryMask[i] = lo.carry;
			v.overflowMask[i] = lo.overflow;
			v.setMask[i] = lo.setFlag;
			v.zeroMask[i] = lo.zero;
		end
		v.allZero = &v.zeroMask;
		return v;
	endfunction

	task automatic checkField(string name, wordT expV, wordT actV);
		if (expV !== actV) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, expV, actV);
		end
	endtask

	always @(posedge clk) begin
		cycle++;
		if (!arstN) begin
			expQ.delete(); // in-flight work is dropped
			dueQ.delete();
		end else begin
			if (resultValid) begin
				if (expQ.size() == 0) begin
					otherErrors++;
					$display("error at %0t: a result came out with nothing issued", $time);
				end else begin
					expVal = expQ.pop_front();
					dueCycle = dueQ.pop_front();
					if (cycle != dueCycle) begin
						otherErrors++;
						$display("error at %0t: result came at cycle %0d, due at cycle %0d",
							$time, cycle, dueCycle);
					end
					for (int i = 0; i < `LANES; i++)
						checkField($sformatf("result[%0d]", i), expVal.result[i], result.result[i]);
					checkField("carryMask", wordT'(expVal.carryMask), wordT'(result.carryMask));
					checkField("overflowMask", wordT'(expVal.overflowMask),
						wordT'(result.overflowMask));
					checkField("setMask", wordT'(expVal.setMask), wordT'(result.setMask));
					checkField("zeroMask", wordT'(expVal.zeroMask), wordT'(result.zeroMask));
					checkField("allZero", wordT'(expVal.allZero), wordT'(result.allZero));
					checked++;
				end
			end
			if (issueValid) begin
				expQ.push_back(vecRef(req));
				dueQ.push_back(cycle + 3);
			end
		end
		pending = expQ.size();
	end

endmodule

// File: verification/vecAlu_assert.sv
`timescale 1ns/1ps
`include "vecAlu_params.svh"

module vecAluAssert import vecAluPkg::*; (
	input logic clk,
	input logic arstN,
	input logic issueValid,
	input logic resultValid,
	input logic [`LANES-1:0] laneValid,
	input vecResultT result
);

	int failCount = 0;

	latency: assert property (@(posedge clk) disable iff (!arstN)
		issueValid |-> ##3 resultValid)
		else begin
			failCount++;
			$error("resultValid did not follow issueValid after 3 cycles");
		end

	resetLow: assert property (@(posedge clk) !arstN |-> !resultValid && laneValid == '0)
		else begin
			failCount++;
			$error("valid signals high while in reset");
		end

	lockstep: assert property (@(posedge clk) (&laneValid) || (laneValid == '0))
		else begin
			failCount++;
			$error("lane valids differ");
		end

	zeroAnd: assert property (@(posedge clk) result.allZero == &result.zeroMask)
		else begin
			failCount++;
			$error("allZero differs from the AND of zeroMask");
		end

endmodule

bind vecAluTop vecAluAssert uAssert (
	.clk(clk),
	.arstN(arstN),
	.issueValid(issueValid),
	.resultValid(resultValid),
	.laneValid(laneValid),
	.result(result)
);

// File: verification/vecAluTb.sv
`timescale 1ns/1ps
`include "vecAlu_params.svh"

module vecAluTb import vecAluPkg::*; ();

	logic clk = 1'b0;
	logic arstN;
	logic issueValid;
	issueReqT req;
	logic resultValid;
	vecResultT result;
	int mismatches;
	int otherErrors;
	int checked;
	int pending;
	int tbErrors;
	int totalOther;
	logic [31:0] lcgState;
	opCodeT intOps [13] = '{5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9,
		5'd10, 5'd12, 5'd14};

	vecAluTop DUT (
		.clk(clk),
		.arstN(arstN),
		.issueValid(issueValid),
		.req(req),
		.resultValid(resultValid),
		.result(result)
	);

	vecAluChecker uCheck (
		.clk(clk),
		.arstN(arstN),
		.issueValid(issueValid),
		.req(req),
		.resultValid(resultValid),
		.result(result),
		.mismatches(mismatches),
		.otherErrors(otherErrors),
		.checked(checked),
		.pending(pending)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic vecT randVec();
		vecT v;
		for (int i = 0; i < `LANES; i++)
			v[i] = lcgNext();
		return v;
	endfunction

	function automatic vecT makeVec(wordT w0, wordT w1, wordT w2, wordT w3);
		return {w3, w2, w1, w0}; // element 0 in the low word
	endfunction

	// strobe held for one cycle from a falling edge
	task automatic issue(vecT a, vecT b, opCodeT opc, logic bcast);
		issueValid = 1'b1;
		req.a = a;
		req.b = b;
		req.opCode = opc;
		req.bcastB = bcast;
		@(negedge clk);
	endtask

	task automatic idle(int n);
		issueValid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic drain();
		int n;
		issueValid = 1'b0;
		n = 0;
		while (pending != 0 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (pending != 0) begin
			tbErrors++;
			$display("timeout: %0d results still outstanding after %0d cycles", pending, n);
		end
	endtask

	initial begin
		vecT v;
		arstN = 1'b0;
		issueValid = 1'b0;
		req = '0;
		lcgState = 32'h2d5a4a4a;
		tbErrors = 0;
		repeat (2) @(negedge clk);
		arstN = 1'b1;
		idle(2);

		foreach (intOps[k]) begin
			repeat (3) issue(randVec(), randVec(), intOps[k], 1'b0);
			v = randVec();
			issue(v, v, intOps[k], 1'b0); // equal operands
			idle(1);
		end

		// carry, overflow and zero edges
		issue(makeVec(32'hffffffff, 32'h7fffffff, 32'h80000000, 0),
			makeVec(1, 1, 32'h80000000, 0), 5'd2, 1'b0);
		issue(makeVec(32'hffffffff, 32'hffffffff, 32'hffffffff, 32'hffffffff),
			makeVec(1, 1, 1, 1), 5'd2, 1'b0);
		issue('0, randVec(), 5'd0, 1'b0);
		drain();

		issue(makeVec(32'h3f800000, 32'h4b000000, 32'h4c000000, 0),
			makeVec(32'h3f800000, 32'h3f800000, 32'h3f800000, 0), 5'd15, 1'b0);
		issue(makeVec(0, 32'h40490fdb, 32'h3fc00000, 32'h00400000),
			makeVec(32'h40490fdb, 0, 32'h3fc00000, 32'h3f800000), 5'd15, 1'b0);
		repeat (4) issue(randVec() & makeVec(32'h7fffffff, 32'h7fffffff, 32'h7fffffff,
			32'h7fffffff), randVec() & {4{32'h7fffffff}}, 5'd15, 1'b0);
		issue(makeVec(32'h3f000000, 32'h40490fdb, 32'h4f000000, 32'h5f800000), '0, 5'd31, 1'b0);
		issue(makeVec(32'h3f800000, 32'h4b7fffff, 32'h4b800000, 32'h42f60000), '0, 5'd31, 1'b0);
		issue(makeVec(0, 1, 32'hffffffff, 32'h12345678), '0, 5'd30, 1'b0);
		issue(makeVec(2, 32'h00800000, 32'h80000000, 32'h7fffffff), '0, 5'd30, 1'b0);
		drain();

		repeat (8) issue(randVec(), randVec(), intOps[4'(lcgNext() % 13)], 1'b1);
		for (int c = 11; c < 30; c++)
			if (c != 12 && c != 14 && c != 15)
				issue(randVec(), randVec(), opCodeT'(c), 1'b0); // runs as add
		drain();

		repeat (24) issue(randVec(), randVec(), opCodeT'(lcgNext() >> 27), 1'(lcgNext() >> 31));
		drain();

		// reset with three instructions in flight
		repeat (3) issue(randVec(), randVec(), 5'd2, 1'b0);
		issueValid = 1'b0;
		arstN = 1'b0;
		repeat (2) begin
			@(negedge clk);
			if (resultValid !== 1'b0) begin
				tbErrors++;
				$display("mismatch at %0t: resultValid expected 0 actual %b", $time, resultValid);
			end
		end
		arstN = 1'b1;
		idle(6);
		issue(randVec(), randVec(), 5'd3, 1'b0);
		issue(randVec(), randVec(), 5'd7, 1'b1);
		drain();
		idle(2);

		totalOther = otherErrors + tbErrors + DUT.uAssert.failCount;
		$display("closing counts: %0d results checked, %0d mismatches, %0d other errors",
			checked, mismatches, totalOther);
		if (mismatches == 0 && totalOther == 0 && checked > 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+common
common/vecAluPkg.sv
aluLane/floatOps.sv
aluLane/aluLane.sv
hw/issueDecode.sv
hw/resultCollect.sv
hw/vecAluTop.sv
verification/vecAluChecker.sv
verification/vecAlu_assert.sv
verification/vecAluTb.sv

// File: run.sh
#!/bin/sh
# build the vector ALU testbench with Verilator, run it, and judge by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module vecAluTb -f sim.f -o vecAluSim \
	&& ./obj_dir/vecAluSim > sim.log 2>&1
grep -qx "TEST PASS" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
